/* Makefile */
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP       ?= backend_tb
RTL_TOP   ?= backend_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+src
src/backend_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_buffer.sv
src/writeback_stage.sv
src/backend_top.sv
tb/backend_tb.sv

/* src/backend_pkg.sv */
// Shared definitions for the in-order back end
// Widths, opcodes, the two-view instruction word and trap vectors

`default_nettype none

package backend_pkg;

    // --------------------
    // Widths and words
    // --------------------

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] data_word_t;

    // Register index into the 32-entry register file
    typedef logic [4:0] reg_idx_t;

    // Trap vector number as seen by the controller
    typedef logic [4:0] trap_vec_t;

    // --------------------
    // Opcodes
    // --------------------

    // Any encoding outside this list commits as an illegal instruction trap
    typedef enum logic [5:0] {
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLEEP = 6'h10,
        OP_MRET  = 6'h11
    } opcode_t;

    // One instruction word with an R view and an I view
    // Opcode, rd and rs1 sit at the same bit positions in both views
    typedef union packed {
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            reg_idx_t    rs2;
            logic [10:0] unused;
        } r;
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            logic [15:0] imm;
        } i;
    } instr_t;

    // Vector numbers need trap_vec_t, so they come in after it
    `include "trap_vectors.svh"

endpackage : backend_pkg

`default_nettype wire

/* src/backend_top.sv */
// Back end top level of the in-order core
// Wires decode, execute, result buffer and writeback around the register file

`timescale 1ns/1ps
`default_nettype none

module backend_top import backend_pkg::*; #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    // Issue handshake
    input  wire logic       issue_valid_i,
    input  wire instr_t     issue_instr_i,
    input  wire data_word_t issue_addr_i,
    output logic            issue_ready_o,
    // Commit side
    input  wire logic       commit_stall_i,
    output logic            commit_write_o,
    output reg_idx_t        commit_rd_o,
    output data_word_t      commit_result_o,
    // Controller
    output logic            exception_o,
    output trap_vec_t       exception_vector_o,
    output data_word_t      exception_addr_o,
    output logic            sleep_o,
    output logic            mreturn_o
);

    // --------------------
    // Internal nets
    // --------------------

    reg_idx_t   rs1, rs2, rf_rd, retire_rd;
    data_word_t rs1_data, rs2_data, rf_wdata;
    logic       rf_we, retire;

    logic       dec_valid;
    opcode_t    dec_op;
    reg_idx_t   dec_rd;
    data_word_t dec_a, dec_b, dec_addr;

    logic       ex_valid, ex_trap;
    reg_idx_t   ex_rd;
    data_word_t ex_result, ex_addr;
    trap_vec_t  ex_vector;

    logic       buf_valid, buf_read, buf_trap;
    reg_idx_t   buf_rd;
    data_word_t buf_result, buf_addr;
    trap_vec_t  buf_vector;

    register_file register_file_i (
        .clk_i, .reset_i,
        .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .rd_i(rf_rd), .wdata_i(rf_wdata)
    );

    decode_stage #(.BUF_DEPTH(BUF_DEPTH)) decode_stage_i (
        .clk_i, .reset_i,
        .issue_valid_i, .issue_instr_i, .issue_addr_i, .issue_ready_o,
        .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .retire_i(retire), .retire_rd_i(retire_rd),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_rd_o(dec_rd),
        .dec_a_o(dec_a), .dec_b_o(dec_b), .dec_addr_o(dec_addr)
    );

    execute_stage execute_stage_i (
        .clk_i, .reset_i,
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_rd_i(dec_rd),
        .dec_a_i(dec_a), .dec_b_i(dec_b), .dec_addr_i(dec_addr),
        .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_result_o(ex_result),
        .ex_trap_o(ex_trap), .ex_vector_o(ex_vector), .ex_addr_o(ex_addr)
    );

    result_buffer #(.BUF_DEPTH(BUF_DEPTH)) result_buffer_i (
        .clk_i, .reset_i,
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
        .ex_trap_i(ex_trap), .ex_vector_i(ex_vector), .ex_addr_i(ex_addr),
        .buf_valid_o(buf_valid), .buf_rd_o(buf_rd), .buf_result_o(buf_result),
        .buf_trap_o(buf_trap), .buf_vector_o(buf_vector), .buf_addr_o(buf_addr),
        .buf_read_i(buf_read)
    );

    // Commit outputs mirror the register file write port
    writeback_stage writeback_stage_i (
        .buf_rd_i(buf_rd), .buf_result_i(buf_result), .buf_trap_i(buf_trap),
        .buf_vector_i(buf_vector), .buf_addr_i(buf_addr),
        .buf_valid_i(buf_valid), .buf_read_o(buf_read), .commit_stall_i,
        .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_wdata_o(rf_wdata),
        .retire_o(retire), .retire_rd_o(retire_rd),
        .sleep_o, .mreturn_o, .exception_o, .exception_vector_o, .exception_addr_o
    );

    assign commit_write_o  = rf_we;
    assign commit_rd_o     = rf_rd;
    assign commit_result_o = rf_wdata;

endmodule : backend_top

`default_nettype wire

/* src/decode_stage.sv */
// Decode stage with issue handshake, busy scoreboard and in-flight credit
// Reads operands and registers the decoded operation for execute

`timescale 1ns/1ps
`default_nettype none

module decode_stage import backend_pkg::*; #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    // Issue handshake
    input  wire logic       issue_valid_i,
    input  wire instr_t     issue_instr_i,
    input  wire data_word_t issue_addr_i,
    output logic            issue_ready_o,
    // Register file read
    output reg_idx_t        rs1_o,
    output reg_idx_t        rs2_o,
    input  wire data_word_t rs1_data_i,
    input  wire data_word_t rs2_data_i,
    // Retire from writeback
    input  wire logic       retire_i,
    input  wire reg_idx_t   retire_rd_i,
    // Decoded operation
    output logic            dec_valid_o,
    output opcode_t         dec_op_o,
    output reg_idx_t        dec_rd_o,
    output data_word_t      dec_a_o,
    output data_word_t      dec_b_o,
    output data_word_t      dec_addr_o
);

    localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

    logic [31:0]      busy;
    logic [CNT_W-1:0] inflight;
    logic             uses_imm;
    logic             uses_rs2;
    logic             hazard;
    logic             accept;

    // --------------------
    // Hazard and credit
    // --------------------

    assign rs1_o = issue_instr_i.r.rs1;
    assign rs2_o = issue_instr_i.r.rs2;

    // Only the R-format ALU ops read a second source register
    assign uses_imm = (issue_instr_i.i.opcode == OP_ADDI);
    assign uses_rs2 = (issue_instr_i.r.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR});

    // Busy bit of x0 never gets set, so x0 never blocks
    assign hazard = busy[issue_instr_i.r.rs1] | busy[issue_instr_i.r.rd]
                  | (uses_rs2 & busy[issue_instr_i.r.rs2]);

    // Stages never stall, so credit must cover decode, execute and the buffer
    assign issue_ready_o = !hazard && (inflight != CNT_W'(BUF_DEPTH));
    assign accept        = issue_valid_i & issue_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy     <= '0;
            inflight <= '0;
        end else begin
            if (retire_i) begin
                busy[retire_rd_i] <= 1'b0;
            end
            if (accept && (issue_instr_i.r.rd != '0)) begin
                busy[issue_instr_i.r.rd] <= 1'b1;
            end
            case ({accept, retire_i})
                2'b10:   inflight <= inflight + CNT_W'(1);
                2'b01:   inflight <= inflight - CNT_W'(1);
                default: inflight <= inflight;
            endcase
        end
    end

    // --------------------
    // Decode register
    // --------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= accept;
        end
    end

    // Operand b picks the sign-extended immediate through the I view
    always_ff @(posedge clk_i) begin
        dec_op_o   <= issue_instr_i.r.opcode;
        dec_rd_o   <= issue_instr_i.r.rd;
        dec_a_o    <= rs1_data_i;
        dec_b_o    <= uses_imm ? {{(XLEN-16){issue_instr_i.i.imm[15]}}, issue_instr_i.i.imm}
                               : rs2_data_i;
        dec_addr_o <= issue_addr_i;
    end

    // A retire from writeback must match an earlier accept still holding its busy bit
    assert_retire_has_issue : assert property (
        @(posedge clk_i) disable iff (reset_i)
        retire_i |-> (inflight != '0) && ((retire_rd_i == '0) || busy[retire_rd_i])
    );

endmodule : decode_stage

`default_nettype wire

/* src/execute_stage.sv */
// Execute stage computing the ALU result or classifying a trap
// Everything is registered once before it goes to the result buffer

`timescale 1ns/1ps
`default_nettype none

module execute_stage import backend_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    // Decoded operation
    input  wire logic       dec_valid_i,
    input  wire opcode_t    dec_op_i,
    input  wire reg_idx_t   dec_rd_i,
    input  wire data_word_t dec_a_i,
    input  wire data_word_t dec_b_i,
    input  wire data_word_t dec_addr_i,
    // Finished entry towards the buffer
    output logic            ex_valid_o,
    output reg_idx_t        ex_rd_o,
    output data_word_t      ex_result_o,
    output logic            ex_trap_o,
    output trap_vec_t       ex_vector_o,
    output data_word_t      ex_addr_o
);

    data_word_t alu_result;
    logic       trap;
    trap_vec_t  vector;

    // --------------------
    // ALU and trap decode
    // --------------------

    // Operand b already holds the immediate for addi
    always_comb begin
        alu_result = '0;
        trap       = 1'b0;
        vector     = '0;
        case (dec_op_i)
            OP_ADD, OP_ADDI: alu_result = dec_a_i + dec_b_i;
            OP_SUB:          alu_result = dec_a_i - dec_b_i;
            OP_AND:          alu_result = dec_a_i & dec_b_i;
            OP_OR:           alu_result = dec_a_i | dec_b_i;
            OP_XOR:          alu_result = dec_a_i ^ dec_b_i;
            OP_SLEEP: begin
                trap   = 1'b1;
                vector = VEC_SLEEP;
            end
            OP_MRET: begin
                trap   = 1'b1;
                vector = VEC_HANDLER_RETURN;
            end
            // Anything else is an unknown opcode
            default: begin
                trap   = 1'b1;
                vector = VEC_ILLEGAL;
            end
        endcase
    end

    // --------------------
    // Execute register
    // --------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    // Trap entries carry a zero result
    always_ff @(posedge clk_i) begin
        ex_rd_o     <= dec_rd_i;
        ex_result_o <= alu_result;
        ex_trap_o   <= trap;
        ex_vector_o <= vector;
        ex_addr_o   <= dec_addr_i;
    end

endmodule : execute_stage

`default_nettype wire

/* src/register_file.sv */
// Register file with 32 words, two combinational read ports and one write port
// Register x0 is hardwired to zero

`timescale 1ns/1ps
`default_nettype none

module register_file import backend_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    // Read ports used by decode
    input  wire reg_idx_t   rs1_i,
    input  wire reg_idx_t   rs2_i,
    output data_word_t      rs1_data_o,
    output data_word_t      rs2_data_o,
    // Write port driven by writeback
    input  wire logic       we_i,
    input  wire reg_idx_t   rd_i,
    input  wire data_word_t wdata_i
);

    data_word_t regs [32];

    // Whole array clears on reset so the model starts from all zeros
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // Index zero reads as zero whatever the array holds
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule : register_file

`default_nettype wire

/* src/result_buffer.sv */
// Result buffer holding finished entries in program order
// Circular FIFO whose head is presented to writeback

`timescale 1ns/1ps
`default_nettype none

module result_buffer import backend_pkg::*; #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    // Write side from execute
    input  wire logic       ex_valid_i,
    input  wire reg_idx_t   ex_rd_i,
    input  wire data_word_t ex_result_i,
    input  wire logic       ex_trap_i,
    input  wire trap_vec_t  ex_vector_i,
    input  wire data_word_t ex_addr_i,
    // Head entry towards writeback
    output logic            buf_valid_o,
    output reg_idx_t        buf_rd_o,
    output data_word_t      buf_result_o,
    output logic            buf_trap_o,
    output trap_vec_t       buf_vector_o,
    output data_word_t      buf_addr_o,
    input  wire logic       buf_read_i
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

    // Pointers carry one wrap bit above the index
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;

    reg_idx_t   rd_mem     [BUF_DEPTH];
    data_word_t result_mem [BUF_DEPTH];
    logic       trap_mem   [BUF_DEPTH];
    trap_vec_t  vector_mem [BUF_DEPTH];
    data_word_t addr_mem   [BUF_DEPTH];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (ex_valid_i) begin
                wr_ptr <= wr_ptr + (PTR_W + 1)'(1);
            end
            if (buf_read_i) begin
                rd_ptr <= rd_ptr + (PTR_W + 1)'(1);
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            rd_mem[wr_ptr[PTR_W-1:0]]     <= ex_rd_i;
            result_mem[wr_ptr[PTR_W-1:0]] <= ex_result_i;
            trap_mem[wr_ptr[PTR_W-1:0]]   <= ex_trap_i;
            vector_mem[wr_ptr[PTR_W-1:0]] <= ex_vector_i;
            addr_mem[wr_ptr[PTR_W-1:0]]   <= ex_addr_i;
        end
    end

    assign buf_valid_o  = !empty;
    assign buf_rd_o     = rd_mem[rd_ptr[PTR_W-1:0]];
    assign buf_result_o = result_mem[rd_ptr[PTR_W-1:0]];
    assign buf_trap_o   = trap_mem[rd_ptr[PTR_W-1:0]];
    assign buf_vector_o = vector_mem[rd_ptr[PTR_W-1:0]];
    assign buf_addr_o   = addr_mem[rd_ptr[PTR_W-1:0]];

    // The issue credit in decode has to keep these from ever firing
    assert_no_write_full  : assert property (
        @(posedge clk_i) disable iff (reset_i) ex_valid_i |-> !full
    );
    assert_no_read_empty  : assert property (
        @(posedge clk_i) disable iff (reset_i) buf_read_i |-> !empty
    );

endmodule : result_buffer

`default_nettype wire

/* src/trap_vectors.svh */
// Trap vector numbers reported to the controller on an exception
// Sleep and handler return ride the same exception path as illegal opcodes

`ifndef TRAP_VECTORS_SVH
`define TRAP_VECTORS_SVH

// Opcode not recognised by the execute stage
localparam trap_vec_t VEC_ILLEGAL        = 5'd2;

// Core asks the controller to enter the low power state
localparam trap_vec_t VEC_SLEEP          = 5'd8;

// Return from the current trap handler
localparam trap_vec_t VEC_HANDLER_RETURN = 5'd9;

`endif

/* src/writeback_stage.sv */
// Writeback stage committing the buffer head
// Writes the register file or reports a trap to the controller

`timescale 1ns/1ps
`default_nettype none

module writeback_stage import backend_pkg::*; (
    // Buffer head
    input  wire reg_idx_t   buf_rd_i,
    input  wire data_word_t buf_result_i,
    input  wire logic       buf_trap_i,
    input  wire trap_vec_t  buf_vector_i,
    input  wire data_word_t buf_addr_i,
    input  wire logic       buf_valid_i,
    output logic            buf_read_o,
    input  wire logic       commit_stall_i,
    // Register file write port
    output logic            rf_we_o,
    output reg_idx_t        rf_rd_o,
    output data_word_t      rf_wdata_o,
    // Scoreboard release in decode
    output logic            retire_o,
    output reg_idx_t        retire_rd_o,
    // Controller
    output logic            sleep_o,
    output logic            mreturn_o,
    output logic            exception_o,
    output trap_vec_t       exception_vector_o,
    output data_word_t      exception_addr_o
);

    // Head leaves the buffer whenever the controller is not stalling commit
    assign buf_read_o = buf_valid_i & !commit_stall_i;
    assign retire_o    = buf_read_o;
    assign retire_rd_o = buf_rd_i;

    assign rf_we_o    = buf_read_o & !buf_trap_i;
    assign rf_rd_o    = buf_rd_i;
    assign rf_wdata_o = buf_result_i;

    assign exception_o        = buf_read_o & buf_trap_i;
    assign exception_vector_o = buf_vector_i;
    assign exception_addr_o   = buf_addr_i;

    // Sleep and handler return are special vectors on the exception path
    assign sleep_o   = exception_o & (buf_vector_i == VEC_SLEEP);
    assign mreturn_o = exception_o & (buf_vector_i == VEC_HANDLER_RETURN);

endmodule : writeback_stage

`default_nettype wire

/* tb/backend_tb.sv */
// Testbench for the back end top level
// Random instruction streams checked against an in-order reference model
// Covers reset state, ALU commits, dependences, traps and commit back-pressure

`timescale 1ns/1ps
`default_nettype none

module backend_tb import backend_pkg::*; ;

    localparam int BUF_DEPTH   = 4;
    localparam int CLK_PERIOD  = 10;
    localparam int N_ALU       = 200;
    localparam int N_DEP       = 60;
    localparam int N_TRAP      = 60;
    localparam int N_TOTAL     = N_ALU + N_DEP + N_TRAP + BUF_DEPTH + 1;
    localparam int WATCHDOG_NS = 20 * N_TOTAL * CLK_PERIOD + 4 * CLK_PERIOD;

    logic       clk_i;
    logic       reset_i;
    logic       issue_valid_i;
    instr_t     issue_instr_i;
    data_word_t issue_addr_i;
    logic       issue_ready_o;
    logic       commit_stall_i;
    logic       commit_write_o;
    reg_idx_t   commit_rd_o;
    data_word_t commit_result_o;
    logic       exception_o;
    trap_vec_t  exception_vector_o;
    data_word_t exception_addr_o;
    logic       sleep_o;
    logic       mreturn_o;

    // Reference model state, updated in issue order
    data_word_t model_regs [32];
    logic       exp_trap [$];
    reg_idx_t   exp_rd [$];
    data_word_t exp_val [$];
    data_word_t exp_addr [$];

    // Fields of the instruction currently on the issue port
    logic [5:0]  cur_op;
    reg_idx_t    cur_rd;
    reg_idx_t    cur_rs1;
    reg_idx_t    cur_rs2;
    logic [15:0] cur_imm;
    data_word_t  cur_addr;

    int          seed;
    int          errors;
    int          checks;
    int          test_errors;
    string       test_name;
    data_word_t  pc;
    reg_idx_t    last_rd;
    logic        stall_force;
    logic [31:0] stall_rnd;

    backend_top #(.BUF_DEPTH(BUF_DEPTH)) backend_top_i (
        .clk_i, .reset_i,
        .issue_valid_i, .issue_instr_i, .issue_addr_i, .issue_ready_o,
        .commit_stall_i, .commit_write_o, .commit_rd_o, .commit_result_o,
        .exception_o, .exception_vector_o, .exception_addr_o, .sleep_o, .mreturn_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog sized from the instruction count of all tests
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the instruction stream did not finish in time");
        $display("Test failed");
        $finish;
    end

    // Commit stall is high about a quarter of the time unless a test forces it
    always @(posedge clk_i) begin
        stall_rnd = $random(seed);
        commit_stall_i <= stall_force | (stall_rnd[1:0] == 2'b00);
    end

    // --------------------
    // Checking
    // --------------------

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // Pops the oldest expected commit and checks the observed one against it
    task automatic check_commit();
        logic       trap;
        reg_idx_t   rd;
        data_word_t val;
        data_word_t addr;
        if (exp_trap.size() == 0) begin
            errors++;
            $display("Error in %s: a commit appeared with no instruction outstanding", test_name);
        end else begin
            trap = exp_trap.pop_front();
            rd   = exp_rd.pop_front();
            val  = exp_val.pop_front();
            addr = exp_addr.pop_front();
            compare("exception flag", 32'(trap), 32'(exception_o));
            compare("write flag", 32'(!trap), 32'(commit_write_o));
            if (!trap) begin
                compare("commit rd", 32'(rd), 32'(commit_rd_o));
                compare("commit result", val, commit_result_o);
            end else begin
                compare("trap vector", val, 32'(exception_vector_o));
                compare("trap address", addr, exception_addr_o);
                compare("sleep", 32'(val == 32'(VEC_SLEEP)), 32'(sleep_o));
                compare("mreturn", 32'(val == 32'(VEC_HANDLER_RETURN)), 32'(mreturn_o));
            end
        end
    endtask

    // Outputs settle between edges, so commits are sampled on the falling edge
    always @(negedge clk_i) begin
        if (!reset_i) begin
            if (commit_stall_i) begin
                compare("commit under stall", 32'd0, 32'(commit_write_o | exception_o));
            end
            if (commit_write_o || exception_o) begin
                check_commit();
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic present(input logic [5:0] op, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, input logic [15:0] imm);
        @(posedge clk_i);
        cur_op   = op;
        cur_rd   = rd;
        cur_rs1  = rs1;
        cur_rs2  = rs2;
        cur_imm  = imm;
        cur_addr = pc;
        last_rd  = rd;
        issue_valid_i <= 1'b1;
        if (op == OP_ADDI) begin
            issue_instr_i <= {op, rd, rs1, imm};
        end else begin
            issue_instr_i <= {op, rd, rs1, rs2, 11'd0};
        end
        issue_addr_i <= pc;
        pc = pc + 32'd4;
    endtask

    // Applies the sequential meaning of the accepted instruction to the model
    task automatic push_expected();
        data_word_t a;
        data_word_t b;
        data_word_t res;
        logic       trap;
        a    = model_regs[cur_rs1];
        b    = model_regs[cur_rs2];
        res  = '0;
        trap = 1'b0;
        case (cur_op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_XOR:   res = a ^ b;
            OP_ADDI:  res = a + {{16{cur_imm[15]}}, cur_imm};
            OP_SLEEP: begin
                trap = 1'b1;
                res  = 32'(VEC_SLEEP);
            end
            OP_MRET:  begin
                trap = 1'b1;
                res  = 32'(VEC_HANDLER_RETURN);
            end
            default:  begin
                trap = 1'b1;
                res  = 32'(VEC_ILLEGAL);
            end
        endcase
        // Register x0 never changes in the model
        if (!trap && (cur_rd != 5'd0)) begin
            model_regs[cur_rd] = res;
        end
        exp_trap.push_back(trap);
        exp_rd.push_back(cur_rd);
        exp_val.push_back(res);
        exp_addr.push_back(cur_addr);
    endtask

    // Transfer happens on the edge after a falling edge that sees ready high
    task automatic wait_accept();
        @(negedge clk_i);
        while (!issue_ready_o) begin
            @(negedge clk_i);
        end
        push_expected();
    endtask

    // Weighted toward addi; a dependent issue reads the previous destination
    task automatic issue_alu(input logic dependent);
        logic [31:0] rnd;
        logic [5:0]  op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        rnd = $random(seed);
        case (rnd[2:0])
            3'd0:    op = OP_ADD;
            3'd1:    op = OP_SUB;
            3'd2:    op = OP_AND;
            3'd3:    op = OP_OR;
            3'd4:    op = OP_XOR;
            default: op = OP_ADDI;
        endcase
        rd  = {2'b00, rnd[10:8]};
        rs1 = dependent ? last_rd : {2'b00, rnd[7:5]};
        if (dependent && (rd == 5'd0)) begin
            rd = 5'd1;
        end
        present(op, rd, rs1, {2'b00, rnd[13:11]}, rnd[31:16]);
        wait_accept();
    endtask

    task automatic issue_trap();
        logic [31:0] rnd;
        logic [5:0]  op;
        rnd = $random(seed);
        case (rnd[1:0])
            2'd0:    op = OP_SLEEP;
            2'd1:    op = OP_MRET;
            2'd2:    op = rnd[7:2];
            default: op = OP_ADDI;
        endcase
        // Redraw until an illegal pick really is an undefined opcode
        while ((rnd[1:0] == 2'd2) && (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                                 OP_ADDI, OP_SLEEP, OP_MRET})) begin
            rnd = $random(seed);
            rnd[1:0] = 2'd2;
            op = rnd[7:2];
        end
        present(op, {2'b00, rnd[10:8]}, {2'b00, rnd[13:11]}, 5'd0, rnd[31:16]);
        wait_accept();
    endtask

    // Fills the credit under stall, holds one more issue back, then releases
    // The extra issue reads x0 and writes a free register, so only the credit blocks it
    task automatic back_pressure();
        logic [31:0] rnd;
        stall_force = 1'b1;
        for (int k = 0; k < BUF_DEPTH; k++) begin
            rnd = $random(seed);
            present(OP_ADDI, 5'(k + 1), 5'd0, 5'd0, rnd[15:0]);
            wait_accept();
        end
        rnd = $random(seed);
        present(OP_ADDI, 5'(BUF_DEPTH + 1), 5'd0, 5'd0, rnd[15:0]);
        repeat (8) begin
            @(negedge clk_i);
            compare("ready with full credit", 32'd0, 32'(issue_ready_o));
        end
        stall_force = 1'b0;
        wait_accept();
    endtask

    // --------------------
    // Test sequence
    // --------------------

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    // Drops valid and waits until every expected commit has been seen
    task automatic end_test();
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        @(negedge clk_i);
        while (exp_trap.size() != 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        $display("[DONE] %s with %0d errors", test_name, errors - test_errors);
    endtask

    initial begin
        seed           = 65749;
        errors         = 0;
        checks         = 0;
        pc             = 32'h0000_1000;
        last_rd        = 5'd0;
        stall_force    = 1'b0;
        reset_i        = 1'b1;
        issue_valid_i  = 1'b0;
        issue_instr_i  = '0;
        issue_addr_i   = '0;
        commit_stall_i = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;

        begin_test("reset_state");
        @(negedge clk_i);
        compare("issue ready", 32'd1, 32'(issue_ready_o));
        compare("commit write", 32'd0, 32'(commit_write_o));
        compare("exception", 32'd0, 32'(exception_o));
        compare("sleep", 32'd0, 32'(sleep_o));
        compare("mreturn", 32'd0, 32'(mreturn_o));
        $display("[DONE] %s with %0d errors", test_name, errors - test_errors);

        begin_test("alu_commits");
        repeat (N_ALU) issue_alu(1'b0);
        end_test();

        begin_test("dependences");
        repeat (N_DEP) issue_alu(1'b1);
        end_test();

        begin_test("traps");
        repeat (N_TRAP) issue_trap();
        end_test();

        begin_test("back_pressure");
        back_pressure();
        end_test();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : backend_tb

`default_nettype wire
